//--- tb.f
+incdir+common
+incdir+tb
common/rp_bus_pkg.sv
common/rp_dsp_pkg.sv
verilog/adc_frontend.sv
pid/pid_prop.sv
verilog/dac_mixer.sv
verilog/sys_regs.sv
verilog/rp_top.sv
tb/tb_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_top
FLIST     := tb.f
VFLAGS    := --binary --timing --assert
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/tb_cases.svh
`ifndef TB_CASES_SVH
`define TB_CASES_SVH

// columns: kind, addr, wdata, adc a, adc b, expected rdata, expected err
// sample rows take their dac values from the model, rnd rows their adc codes from the lfsr
localparam int N_CASES = 42;

localparam row_t CASES [N_CASES] = '{
  '{K_SMP, 32'h0000_0000, 32'h0000_0000, 14'h0123, 14'h3abc, 32'h0, 1'b0},  // reset config
  '{K_RD,  32'h0000_0000, 32'h0000_0000, 14'h0, 14'h0, `RP_ID_VALUE, 1'b0},  // id word
  '{K_WR,  32'h0000_0004, 32'h0000_00a5, 14'h0, 14'h0, 32'h0, 1'b0},         // leds
  '{K_RD,  32'h0000_0004, 32'h0000_0000, 14'h0, 14'h0, 32'h0000_00a5, 1'b0},
  '{K_RD,  32'h0000_0008, 32'h0000_0000, 14'h0, 14'h0, 32'h0, 1'b0},         // hk hole
  '{K_WR,  32'h0030_0008, 32'h0000_dead, 14'h0, 14'h0, 32'h0, 1'b0},         // pid hole
  '{K_RD,  32'h0030_0008, 32'h0000_0000, 14'h0, 14'h0, 32'h0, 1'b0},
  '{K_WR,  32'h0010_0000, 32'h0000_0001, 14'h0, 14'h0, 32'h0, 1'b1},         // scope
  '{K_RD,  32'h0040_0000, 32'h0000_0000, 14'h0, 14'h0, 32'h0, 1'b1},         // ams
  '{K_RD,  32'h0050_0010, 32'h0000_0000, 14'h0, 14'h0, 32'h0, 1'b1},         // daisy
  '{K_WR,  32'h0060_0000, 32'h0000_0003, 14'h0, 14'h0, 32'h0, 1'b1},         // digdar
  '{K_RD,  32'h0070_0004, 32'h0000_0000, 14'h0, 14'h0, 32'h0, 1'b1},         // test
  '{K_WR,  32'h0020_0000, 32'h0000_0200, 14'h0, 14'h0, 32'h0, 1'b0},         // off a +512
  '{K_WR,  32'h0020_0004, 32'h0000_3e00, 14'h0, 14'h0, 32'h0, 1'b0},         // off b -512
  '{K_RD,  32'h0020_0000, 32'h0000_0000, 14'h0, 14'h0, 32'h0000_0200, 1'b0},
  '{K_RD,  32'h0020_0004, 32'h0000_0000, 14'h0, 14'h0, 32'h0000_3e00, 1'b0},
  '{K_SMP, 32'h0000_0000, 32'h0000_0000, 14'h1000, 14'h2000, 32'h0, 1'b0},  // offsets only
  '{K_WR,  32'h0030_0010, 32'h0000_0100, 14'h0, 14'h0, 32'h0, 1'b0},         // sp a 256
  '{K_WR,  32'h0030_0014, 32'h0000_1000, 14'h0, 14'h0, 32'h0, 1'b0},         // kp a unity
  '{K_WR,  32'h0030_0020, 32'h0000_3f00, 14'h0, 14'h0, 32'h0, 1'b0},         // sp b -256
  '{K_WR,  32'h0030_0024, 32'h0000_0800, 14'h0, 14'h0, 32'h0, 1'b0},         // kp b half
  '{K_RD,  32'h0030_0010, 32'h0000_0000, 14'h0, 14'h0, 32'h0000_0100, 1'b0},
  '{K_RD,  32'h0030_0014, 32'h0000_0000, 14'h0, 14'h0, 32'h0000_1000, 1'b0},
  '{K_RD,  32'h0030_0020, 32'h0000_0000, 14'h0, 14'h0, 32'h0000_3f00, 1'b0},
  '{K_RD,  32'h0030_0024, 32'h0000_0000, 14'h0, 14'h0, 32'h0000_0800, 1'b0},
  '{K_WR,  32'h0030_0000, 32'h0000_0003, 14'h0, 14'h0, 32'h0, 1'b0},         // both enabled
  '{K_RD,  32'h0030_0000, 32'h0000_0000, 14'h0, 14'h0, 32'h0000_0003, 1'b0},
  '{K_SMP, 32'h0000_0000, 32'h0000_0000, 14'h1fff, 14'h2000, 32'h0, 1'b0},  // samples 0 and -1
  '{K_LAT, 32'h0000_0000, 32'h0000_0000, 14'h0f00, 14'h3100, 32'h0, 1'b0},  // latency step
  '{K_RND, 32'h0000_0000, 32'h0000_0000, 14'h0, 14'h0, 32'h0, 1'b0},
  '{K_RND, 32'h0000_0000, 32'h0000_0000, 14'h0, 14'h0, 32'h0, 1'b0},
  '{K_RND, 32'h0000_0000, 32'h0000_0000, 14'h0, 14'h0, 32'h0, 1'b0},
  '{K_RND, 32'h0000_0000, 32'h0000_0000, 14'h0, 14'h0, 32'h0, 1'b0},
  '{K_WR,  32'h0030_0014, 32'h0000_1fff, 14'h0, 14'h0, 32'h0, 1'b0},         // kp a near 2
  '{K_WR,  32'h0020_0000, 32'h0000_1f00, 14'h0, 14'h0, 32'h0, 1'b0},         // off a +7936
  '{K_WR,  32'h0030_0024, 32'h0000_1fff, 14'h0, 14'h0, 32'h0, 1'b0},         // kp b near 2
  '{K_WR,  32'h0020_0004, 32'h0000_2100, 14'h0, 14'h0, 32'h0, 1'b0},         // off b -7936
  '{K_SMP, 32'h0000_0000, 32'h0000_0000, 14'h3f3f, 14'h00bf, 32'h0, 1'b0},  // both limits
  '{K_WR,  32'h0030_0014, 32'h0000_3000, 14'h0, 14'h0, 32'h0, 1'b0},         // kp a -1
  '{K_RND, 32'h0000_0000, 32'h0000_0000, 14'h0, 14'h0, 32'h0, 1'b0},
  '{K_RND, 32'h0000_0000, 32'h0000_0000, 14'h0, 14'h0, 32'h0, 1'b0},
  '{K_RD,  32'h0000_0004, 32'h0000_0000, 14'h0, 14'h0, 32'h0000_00a5, 1'b0}  // leds kept
};

`endif

//--- tb/tb_top.sv
`timescale 1ns/1ns
`include "rp_macros.svh"

module tb_top;

  import rp_bus_pkg::*;
  import rp_dsp_pkg::*;

  typedef enum logic [2:0] {K_WR, K_RD, K_SMP, K_LAT, K_RND} kind_e;

  typedef struct packed {
    kind_e       kind;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [13:0] adc_a;
    logic [13:0] adc_b;
    logic [31:0] exp;      // rdata of a read
    logic        exp_err;
  } row_t;

  `include "tb_cases.svh"

  localparam int          WD_NS     = N_CASES * 20 * 40;  // 20 cycles per row
  localparam logic [13:0] ZERO_CODE = 14'h1fff;            // sample 0, low bits inverted

  logic     adc_clk;
  logic     arst_n_i;
  adc_raw_t adc_raw_a, adc_raw_b;
  sys_req_t sys_req;
  sys_rsp_t rsp;
  adc_raw_t dac_a, dac_b;
  logic [7:0] led;

  logic [31:0] lfsr_q;                        // random adc codes
  int          sp_a, kp_a, sp_b, kp_b;        // config written so far
  int          off_a, off_b;
  logic        en_a, en_b;
  logic [7:0]  led_sh;

  rp_top DUT (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .adc_raw_a_i (adc_raw_a),
    .adc_raw_b_i (adc_raw_b),
    .sys_req_i   (sys_req),
    .sys_rsp_o   (rsp),
    .dac_a_o     (dac_a),
    .dac_b_o     (dac_b),
    .led_o       (led)
  );

  initial begin
    adc_clk = 1'b0;
    forever #20 adc_clk = ~adc_clk;  // 40 ns period
  end

  // ------------------------------
  // error handling
  task automatic abort_run();
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  // ------------------------------
  // lfsr, x^32+x^22+x^2+x+1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_code(output logic [13:0] v);
    v = '0;
    repeat (14) begin
      lfsr_q = lfsr_step(lfsr_q);  // one step per bit
      v      = {v[12:0], lfsr_q[0]};
    end
  endtask

  // ------------------------------
  // reference model of the sample path
  function automatic int limit14(input int v);
    if (v > 8191) return 8191;
    if (v < -8192) return -8192;
    return v;
  endfunction

  function automatic logic [13:0] model_dac(input logic [13:0] raw, input int sp, input int kp,
                                            input int off, input logic en);
    logic signed [13:0] smp14;
    int smp, e, ctl, sum;
    smp14 = raw ^ 14'h1fff;                          // negative slope, msb kept
    smp   = int'(smp14);
    e     = sp - smp;
    ctl   = en ? limit14((e * kp) >>> 12) : 0;       // disabled ch gives 0
    sum   = limit14(ctl + off);
    return sum[13:0] ^ 14'h1fff;                     // back to dac code
  endfunction

  task automatic update_shadow(input logic [31:0] addr, input logic [31:0] wdata);
    logic signed [13:0] v;
    logic [19:0]        ofs;
    v   = wdata[13:0];
    ofs = addr[19:0];
    case (region_e'(addr[22:20]))
      REG_HK: if (ofs == `RP_OFS_LED) led_sh = wdata[7:0];
      REG_OFFSET: begin
        if (ofs == `RP_OFS_OFFSET_A) off_a = int'(v);
        if (ofs == `RP_OFS_OFFSET_B) off_b = int'(v);
      end
      REG_PID: begin
        case (ofs)
          `RP_OFS_CTRL: begin
            en_a = wdata[0];
            en_b = wdata[1];
          end
          `RP_OFS_SP_A: sp_a = int'(v);
          `RP_OFS_KP_A: kp_a = int'(v);
          `RP_OFS_SP_B: sp_b = int'(v);
          `RP_OFS_KP_B: kp_b = int'(v);
          default: ;  // holes keep the config
        endcase
      end
      default: ;
    endcase
  endtask

  // ------------------------------
  // row drivers
  task automatic bus_row(input row_t r);
    logic wr;
    wr = (r.kind == K_WR);
    @(posedge adc_clk);
    sys_req <= '{addr: r.addr, wdata: r.wdata, wen: wr, ren: !wr};
    @(negedge adc_clk);
    check_val("ack", 32'(rsp.ack), 32'h0);     // not in the strobe cycle
    @(posedge adc_clk);
    sys_req.wen <= 1'b0;
    sys_req.ren <= 1'b0;
    @(negedge adc_clk);
    check_val("ack", 32'(rsp.ack), 32'h1);     // one cycle after the strobe
    check_val("err", 32'(rsp.err), 32'(r.exp_err));
    if (!wr && !r.exp_err) check_val("rdata", rsp.rdata, r.exp);
    if (wr) update_shadow(r.addr, r.wdata);
    check_val("led_o", 32'(led), 32'(led_sh));  // new value with the ack
    @(negedge adc_clk);
    check_val("ack", 32'(rsp.ack), 32'h0);     // single pulse
    check_val("err", 32'(rsp.err), 32'h0);
  endtask

  task automatic sample_row(input logic [13:0] a, input logic [13:0] b, input logic lat);
    logic [13:0] prev_a, prev_b, exp_a, exp_b;
    int k;
    prev_a = dac_a;
    prev_b = dac_b;
    exp_a  = model_dac(a, sp_a, kp_a, off_a, en_a);
    exp_b  = model_dac(b, sp_b, kp_b, off_b, en_b);
    @(posedge adc_clk);
    adc_raw_a <= a;
    adc_raw_b <= b;
    @(negedge adc_clk);
    for (k = 1; k <= 6; k++) begin
      @(negedge adc_clk);                    // after edge k
      check_val("ack", 32'(rsp.ack), 32'h0);
      if (lat && k < 4) begin
        check_val("dac_a_o", 32'(dac_a), 32'(prev_a));  // still in flight
        check_val("dac_b_o", 32'(dac_b), 32'(prev_b));
      end
      if ((lat && k == 4) || k == 6) begin
        check_val("dac_a_o", 32'(dac_a), 32'(exp_a));
        check_val("dac_b_o", 32'(dac_b), 32'(exp_b));
      end
    end
  endtask

  task automatic run_row(input row_t r);
    logic [13:0] a, b;
    a = r.adc_a;
    b = r.adc_b;
    case (r.kind)
      K_WR, K_RD: bus_row(r);
      K_LAT:      sample_row(a, b, 1'b1);
      K_RND: begin
        rand_code(a);
        rand_code(b);
        sample_row(a, b, 1'b0);
      end
      default:    sample_row(a, b, 1'b0);
    endcase
  endtask

  task automatic post_reset_check();
    repeat (3) begin
      @(negedge adc_clk);
      check_val("dac_a_o", 32'(dac_a), 32'(ZERO_CODE));
      check_val("dac_b_o", 32'(dac_b), 32'(ZERO_CODE));
      check_val("ack", 32'(rsp.ack), 32'h0);
      check_val("err", 32'(rsp.err), 32'h0);
      check_val("led_o", 32'(led), 32'h0);
    end
  endtask

  // ------------------------------
  // main sequence
  initial begin
    int i;
    arst_n_i  = 1'b0;
    adc_raw_a = '0;
    adc_raw_b = '0;
    sys_req   = '0;
    lfsr_q    = 32'h41cb_6450;
    {sp_a, kp_a, sp_b, kp_b, off_a, off_b} = '0;
    en_a      = 1'b0;
    en_b      = 1'b0;
    led_sh    = '0;
    repeat (2) @(posedge adc_clk);
    arst_n_i <= 1'b1;
    post_reset_check();
    for (i = 0; i < N_CASES; i++) begin
      run_row(CASES[i]);
    end
    $display("all tests passed");
    $finish;
  end

  // watchdog
  initial begin
    #(WD_NS);
    $display("timeout: the table did not finish within %0d ns", WD_NS);
    abort_run();
  end

endmodule

//--- verilog/rp_top.sv
`timescale 1ns/1ns

module rp_top (
  input  logic                 adc_clk,
  input  logic                 arst_n_i,
  input  rp_dsp_pkg::adc_raw_t adc_raw_a_i,  // adc ch a
  input  rp_dsp_pkg::adc_raw_t adc_raw_b_i,  // adc ch b
  input  rp_bus_pkg::sys_req_t sys_req_i,    // system bus
  output rp_bus_pkg::sys_rsp_t sys_rsp_o,
  output rp_dsp_pkg::adc_raw_t dac_a_o,      // dac ch a, 4 cycles after adc
  output rp_dsp_pkg::adc_raw_t dac_b_o,
  output logic [7:0]           led_o
);

  import rp_dsp_pkg::*;

  ch_pair_t smp;      // stage 1 out
  ch_pair_t ctl;      // stage 2 out
  pid_cfg_t pid_cfg;
  mix_cfg_t mix_cfg;

  // ------------------------------
  // sample path
  adc_frontend i_adc (
    .adc_clk  (adc_clk),
    .arst_n_i (arst_n_i),
    .adc_a_i  (adc_raw_a_i),
    .adc_b_i  (adc_raw_b_i),
    .smp_o    (smp)
  );

  pid_prop i_pid (
    .adc_clk  (adc_clk),
    .arst_n_i (arst_n_i),
    .smp_i    (smp),
    .cfg_i    (pid_cfg),
    .ctl_o    (ctl)
  );

  dac_mixer i_mix (
    .adc_clk  (adc_clk),
    .arst_n_i (arst_n_i),
    .ctl_i    (ctl),
    .cfg_i    (mix_cfg),
    .dac_a_o  (dac_a_o),
    .dac_b_o  (dac_b_o)
  );

  // ------------------------------
  // register block
  sys_regs i_regs (
    .adc_clk   (adc_clk),
    .arst_n_i  (arst_n_i),
    .req_i     (sys_req_i),
    .rsp_o     (sys_rsp_o),
    .pid_cfg_o (pid_cfg),
    .mix_cfg_o (mix_cfg),
    .led_o     (led_o)
  );

endmodule

//--- verilog/sys_regs.sv
`timescale 1ns/1ns
`include "rp_macros.svh"

module sys_regs (
  input  logic                 adc_clk,
  input  logic                 arst_n_i,
  input  rp_bus_pkg::sys_req_t req_i,      // plain strobes
  output rp_bus_pkg::sys_rsp_t rsp_o,      // ack one cycle later
  output rp_dsp_pkg::pid_cfg_t pid_cfg_o,  // controller settings
  output rp_dsp_pkg::mix_cfg_t mix_cfg_o,  // dc offsets
  output logic [7:0]           led_o
);

  import rp_bus_pkg::*;
  import rp_dsp_pkg::*;

  // registers read back as unsigned 14 bit fields
  function automatic logic [31:0] zext(input logic [`RP_ADC_W-1:0] v);
    return 32'(v);
  endfunction

  region_e                region;
  logic [`RP_REG_LSB-1:0] ofs;       // offset inside the region
  logic                   strobe;
  logic                   impl;      // hk, offset or pid
  logic [31:0]            rd_data;
  logic [31:0]            rdata_q;
  logic                   ack_q, err_q;
  logic [7:0]             led_q;
  pid_cfg_t               pid_q;
  mix_cfg_t               mix_q;

  assign region = region_e'(req_i.addr[`RP_REG_MSB:`RP_REG_LSB]);
  assign ofs    = req_i.addr[`RP_REG_LSB-1:0];
  assign strobe = req_i.wen | req_i.ren;
  assign impl   = region inside {REG_HK, REG_OFFSET, REG_PID};

  // ------------------------------
  // read mux, unknown offsets give 0
  always_comb begin
    rd_data = '0;
    case (region)
      REG_HK: begin
        if (ofs == '0)                rd_data = `RP_ID_VALUE;
        else if (ofs == `RP_OFS_LED)  rd_data = {24'h0, led_q};
      end
      REG_OFFSET: begin
        if (ofs == `RP_OFS_OFFSET_A)      rd_data = zext(mix_q.off_a);
        else if (ofs == `RP_OFS_OFFSET_B) rd_data = zext(mix_q.off_b);
      end
      REG_PID: begin
        case (ofs)
          `RP_OFS_CTRL: rd_data = {30'h0, pid_q.en_b, pid_q.en_a};
          `RP_OFS_SP_A: rd_data = zext(pid_q.sp_a);
          `RP_OFS_KP_A: rd_data = zext(pid_q.kp_a);
          `RP_OFS_SP_B: rd_data = zext(pid_q.sp_b);
          `RP_OFS_KP_B: rd_data = zext(pid_q.kp_b);
          default: ;
        endcase
      end
      default: ;  // other regions only answer with err
    endcase
  end

  // ------------------------------
  // handshake and config writes
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
      led_q <= '0;
      pid_q <= '0;
      mix_q <= '0;
    end else begin
      ack_q <= strobe;           // one ack per strobe
      err_q <= strobe & ~impl;
      if (req_i.wen) begin
        case (region)
          REG_HK: if (ofs == `RP_OFS_LED) led_q <= req_i.wdata[7:0];
          REG_OFFSET: begin
            if (ofs == `RP_OFS_OFFSET_A) mix_q.off_a <= sample_t'(req_i.wdata[`RP_ADC_W-1:0]);
            if (ofs == `RP_OFS_OFFSET_B) mix_q.off_b <= sample_t'(req_i.wdata[`RP_ADC_W-1:0]);
          end
          REG_PID: begin
            case (ofs)
              `RP_OFS_CTRL: {pid_q.en_b, pid_q.en_a} <= req_i.wdata[1:0];
              `RP_OFS_SP_A: pid_q.sp_a <= sample_t'(req_i.wdata[`RP_ADC_W-1:0]);
              `RP_OFS_KP_A: pid_q.kp_a <= gain_t'(req_i.wdata[`RP_KP_W-1:0]);
              `RP_OFS_SP_B: pid_q.sp_b <= sample_t'(req_i.wdata[`RP_ADC_W-1:0]);
              `RP_OFS_KP_B: pid_q.kp_b <= gain_t'(req_i.wdata[`RP_KP_W-1:0]);
              default: ;  // unknown offset, write dropped
            endcase
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (req_i.ren) rdata_q <= rd_data;  // held until the next read
  end

  assign rsp_o     = '{rdata: rdata_q, ack: ack_q, err: err_q};
  assign pid_cfg_o = pid_q;
  assign mix_cfg_o = mix_q;
  assign led_o     = led_q;

  a_one_strobe: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    !(req_i.wen && req_i.ren));
  // ack is a one cycle pulse
  a_ack_single: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    rsp_o.ack |=> !rsp_o.ack);

endmodule

//--- verilog/dac_mixer.sv
`timescale 1ns/1ns
`include "rp_macros.svh"

module dac_mixer (
  input  logic                 adc_clk,
  input  logic                 arst_n_i,
  input  rp_dsp_pkg::ch_pair_t ctl_i,     // controller output
  input  rp_dsp_pkg::mix_cfg_t cfg_i,     // dc offsets
  output rp_dsp_pkg::adc_raw_t dac_a_o,   // dac code ch a
  output rp_dsp_pkg::adc_raw_t dac_b_o    // dac code ch b
);

  import rp_dsp_pkg::*;

  localparam int SUM_W = `RP_SUM_W;

  typedef logic signed [SUM_W-1:0] sum_t;

  // top two bits differ on overflow
  function automatic sample_t clamp(input sum_t s);
    case (s[SUM_W-1 -: 2])
      2'b01:   return SMP_MAX;  // pos overflow, 0x1fff
      2'b10:   return SMP_MIN;  // neg overflow, 0x2000
      default: return s[`RP_ADC_W-1:0];
    endcase
  endfunction

  sum_t sum_a, sum_b;

  assign sum_a = sum_t'(ctl_i.a) + sum_t'(cfg_i.off_a);  // offset replaces signal gen
  assign sum_b = sum_t'(ctl_i.b) + sum_t'(cfg_i.off_b);

  // ------------------------------
  // output register in dac code
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dac_a_o <= smp2raw('0);  // code of sample 0
      dac_b_o <= smp2raw('0);
    end else begin
      dac_a_o <= smp2raw(clamp(sum_a));
      dac_b_o <= smp2raw(clamp(sum_b));
    end
  end

  // overflowed sums show up clamped at the pins
  a_clamp_a: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    (sum_a[SUM_W-1] != sum_a[SUM_W-2]) |=>
      (dac_a_o == smp2raw($past(sum_a[SUM_W-1]) ? SMP_MIN : SMP_MAX)));
  a_clamp_b: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    (sum_b[SUM_W-1] != sum_b[SUM_W-2]) |=>
      (dac_b_o == smp2raw($past(sum_b[SUM_W-1]) ? SMP_MIN : SMP_MAX)));

endmodule

//--- pid/pid_prop.sv
`timescale 1ns/1ns
`include "rp_macros.svh"

module pid_prop (
  input  logic                 adc_clk,
  input  logic                 arst_n_i,
  input  rp_dsp_pkg::ch_pair_t smp_i,   // from adc frontend
  input  rp_dsp_pkg::pid_cfg_t cfg_i,   // setpoints, gains, enables
  output rp_dsp_pkg::ch_pair_t ctl_o    // controller output, 2 cycles
);

  import rp_dsp_pkg::*;

  localparam int SUM_W  = `RP_SUM_W;
  localparam int PROD_W = `RP_SUM_W + `RP_KP_W;  // full error x gain width

  typedef logic signed [SUM_W-1:0]  err_t;
  typedef logic signed [PROD_W-1:0] prod_t;

  // {pos, neg}; bits above the sample msb must all equal the sign
  function automatic logic [1:0] ovf(input prod_t v);
    logic [PROD_W-`RP_ADC_W:0] top;
    top = v[PROD_W-1:`RP_ADC_W-1];
    return {~top[PROD_W-`RP_ADC_W] & |top, top[PROD_W-`RP_ADC_W] & ~&top};
  endfunction

  function automatic sample_t clamp(input prod_t v, input logic [1:0] f);
    if (f[1]) return SMP_MAX;   // pos overflow
    if (f[0]) return SMP_MIN;   // neg overflow
    return v[`RP_ADC_W-1:0];
  endfunction

  err_t       err_a, err_b;     // stage 2a
  prod_t      shr_a, shr_b;     // scaled product, before saturation
  logic [1:0] ovf_a, ovf_b;
  ch_pair_t   ctl_q;            // stage 2b

  // ------------------------------
  // error register
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      err_a <= '0;
      err_b <= '0;
    end else begin
      err_a <= err_t'(cfg_i.sp_a) - err_t'(smp_i.a);  // 15 bit, cannot wrap
      err_b <= err_t'(cfg_i.sp_b) - err_t'(smp_i.b);
    end
  end

  // ------------------------------
  // gain, shift and saturate
  assign shr_a = (prod_t'(err_a) * prod_t'(cfg_i.kp_a)) >>> `RP_PSR;
  assign shr_b = (prod_t'(err_b) * prod_t'(cfg_i.kp_b)) >>> `RP_PSR;
  assign ovf_a = ovf(shr_a);
  assign ovf_b = ovf(shr_b);

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ctl_q <= '0;
    end else begin
      ctl_q.a <= cfg_i.en_a ? clamp(shr_a, ovf_a) : '0;  // disabled ch gives 0
      ctl_q.b <= cfg_i.en_b ? clamp(shr_b, ovf_b) : '0;
    end
  end

  assign ctl_o = ctl_q;

  // flag logic and numeric range must agree
  a_sat_range: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    ((ovf_a == 2'b00) |-> (shr_a <= prod_t'(SMP_MAX) && shr_a >= prod_t'(SMP_MIN))) and
    ((ovf_b == 2'b00) |-> (shr_b <= prod_t'(SMP_MAX) && shr_b >= prod_t'(SMP_MIN))));

endmodule

//--- verilog/adc_frontend.sv
`timescale 1ns/1ns

module adc_frontend (
  input  logic                 adc_clk,
  input  logic                 arst_n_i,
  input  rp_dsp_pkg::adc_raw_t adc_a_i,   // raw code ch a
  input  rp_dsp_pkg::adc_raw_t adc_b_i,   // raw code ch b
  output rp_dsp_pkg::ch_pair_t smp_o      // signed samples, 1 cycle later
);

  import rp_dsp_pkg::*;

  ch_pair_t smp_q;  // stage 1 register

  // ------------------------------
  // capture and convert
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      smp_q <= '0;                   // sample 0 after reset
    end else begin
      smp_q.a <= raw2smp(adc_a_i);   // neg slope to two's complement
      smp_q.b <= raw2smp(adc_b_i);
    end
  end

  assign smp_o = smp_q;

endmodule

//--- common/rp_dsp_pkg.sv
`include "rp_macros.svh"

package rp_dsp_pkg;

  typedef logic signed [`RP_ADC_W-1:0] sample_t;   // two's complement sample
  typedef logic        [`RP_ADC_W-1:0] adc_raw_t;  // unsigned, negative slope
  typedef logic signed [`RP_KP_W-1:0]  gain_t;     // proportional gain

  typedef struct packed {
    sample_t a;
    sample_t b;
  } ch_pair_t;

  typedef struct packed {
    sample_t sp_a;  // setpoints and gains per channel
    gain_t   kp_a;
    sample_t sp_b;
    gain_t   kp_b;
    logic    en_a;
    logic    en_b;
  } pid_cfg_t;

  typedef struct packed {
    sample_t off_a;
    sample_t off_b;
  } mix_cfg_t;

  localparam sample_t SMP_MAX = {1'b0, {(`RP_ADC_W-1){1'b1}}};  // 8191
  localparam sample_t SMP_MIN = {1'b1, {(`RP_ADC_W-1){1'b0}}};  // -8192

  // converter slope is inverted, so all bits but the msb flip
  function automatic sample_t raw2smp(input adc_raw_t r);
    return {r[`RP_ADC_W-1], ~r[`RP_ADC_W-2:0]};
  endfunction

  function automatic adc_raw_t smp2raw(input sample_t s);
    return {s[`RP_ADC_W-1], ~s[`RP_ADC_W-2:0]};  // same rule in reverse
  endfunction

endpackage

//--- common/rp_bus_pkg.sv
`include "rp_macros.svh"

package rp_bus_pkg;

  // one request per cycle at most, full word writes only
  typedef struct packed {
    logic [31:0] addr;   // byte address
    logic [31:0] wdata;  // write data
    logic        wen;    // write strobe
    logic        ren;    // read strobe
  } sys_req_t;

  typedef struct packed {
    logic [31:0] rdata;  // valid with ack
    logic        ack;    // one cycle after the strobe
    logic        err;    // region not implemented
  } sys_rsp_t;

  // address bits 22..20
  typedef enum logic [`RP_REG_MSB-`RP_REG_LSB:0] {
    REG_HK     = 3'd0,  // id and leds
    REG_SCOPE  = 3'd1,
    REG_OFFSET = 3'd2,  // dc offsets
    REG_PID    = 3'd3,  // controller
    REG_AMS    = 3'd4,
    REG_DAISY  = 3'd5,
    REG_DIGDAR = 3'd6,
    REG_TEST   = 3'd7
  } region_e;

endpackage

//--- common/rp_macros.svh
`ifndef RP_MACROS_SVH
`define RP_MACROS_SVH

// sample path widths
`define RP_ADC_W         14            // adc and dac code width
`define RP_SUM_W         15            // one guard bit for sums and errors
`define RP_KP_W          14            // signed proportional gain
`define RP_PSR           12            // gain product shift, kp of 4096 is unity

// system bus address map
`define RP_REG_LSB       20            // region field low bit
`define RP_REG_MSB       22            // region field high bit
`define RP_ID_VALUE      32'h5250_0001 // housekeeping id word

// register offsets inside a region
`define RP_OFS_LED       20'h00004     // housekeeping
`define RP_OFS_OFFSET_A  20'h00000     // offset region
`define RP_OFS_OFFSET_B  20'h00004
`define RP_OFS_CTRL      20'h00000     // controller region, bit0 en a, bit1 en b
`define RP_OFS_SP_A      20'h00010
`define RP_OFS_KP_A      20'h00014
`define RP_OFS_SP_B      20'h00020
`define RP_OFS_KP_B      20'h00024

`endif
